// File: rtl/cache_pkg.sv
package cache_pkg;

    localparam int addr_w      = 14;
    localparam int data_w      = 32;
    localparam int offset_w    = 2;
    localparam int index_w     = 4;
    localparam int tag_w       = 8;
    localparam int num_lines   = 16;
    localparam int mem_words   = 4096;
    localparam int mem_aw      = 12;
    localparam int mem_latency = 3;
    localparam int lat_cnt_w   = $clog2(mem_latency + 1);

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic              wr;
    } cpu_req_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic              wr;
    } mem_req_t;

    typedef struct packed {
        logic              valid;
        logic              dirty;
        logic [tag_w-1:0]  tag;
        logic [data_w-1:0] data;
    } cache_line_t;

    typedef enum logic [1:0] {
        I_IDLE,
        I_COMPARE,
        I_ALLOCATE
    } icache_state_t;

    typedef enum logic [1:0] {
        D_IDLE,
        D_COMPARE,
        D_WRITE_BACK,
        D_ALLOCATE
    } dcache_state_t;

    function automatic logic [index_w-1:0] addr_index(input logic [addr_w-1:0] addr);
        return addr[offset_w+index_w-1:offset_w];
    endfunction

    function automatic logic [tag_w-1:0] addr_tag(input logic [addr_w-1:0] addr);
        return addr[addr_w-1:addr_w-tag_w];
    endfunction

    function automatic logic [mem_aw-1:0] word_addr(input logic [addr_w-1:0] addr);
        return addr[addr_w-1:offset_w];
    endfunction

endpackage

// File: rtl/icache.sv
`timescale 1ns/1ns

module icache
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_valid,
    input  cpu_req_t          cpu_req,
    output logic              cpu_ready,
    output logic [data_w-1:0] cpu_rdata,
    output logic              mem_valid,
    output mem_req_t          mem_req,
    input  logic              mem_ready,
    input  logic [data_w-1:0] mem_rdata
);

    icache_state_t     state;
    icache_state_t     next_state;
    cache_line_t       lines [num_lines];
    cache_line_t       cur_line;
    logic [index_w-1:0] index;
    logic [tag_w-1:0]   tag;
    logic               hit;

    assign index    = addr_index(cpu_req.addr);
    assign tag      = addr_tag(cpu_req.addr);
    assign cur_line = lines[index];
    assign hit      = cur_line.valid && (cur_line.tag == tag);

    assign cpu_ready = (state == I_COMPARE) && hit;
    assign cpu_rdata = cur_line.data;

    // Fetch is always a word-aligned read
    assign mem_valid     = (state == I_ALLOCATE);
    assign mem_req.addr  = {cpu_req.addr[addr_w-1:offset_w], {offset_w{1'b0}}};
    assign mem_req.wdata = '0;
    assign mem_req.wr    = 1'b0;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= I_IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            I_IDLE:
            begin
                if (cpu_valid)
                    next_state = I_COMPARE;
            end
            I_COMPARE:
            begin
                next_state = hit ? I_IDLE : I_ALLOCATE;
            end
            I_ALLOCATE:
            begin
                if (mem_ready)
                    next_state = I_COMPARE;
            end
            default:
            begin
                next_state = I_IDLE;
            end
        endcase
    end

    // The refilled line is answered from COMPARE on the following cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < num_lines; i++)
                lines[i] <= '0;
        end
        else if (state == I_ALLOCATE && mem_ready)
        begin
            lines[index].valid <= 1'b1;
            lines[index].dirty <= 1'b0;
            lines[index].tag   <= tag;
            lines[index].data  <= mem_rdata;
        end
    end

endmodule

// File: rtl/dcache.sv
`timescale 1ns/1ns

module dcache
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_valid,
    input  cpu_req_t          cpu_req,
    output logic              cpu_ready,
    output logic [data_w-1:0] cpu_rdata,
    output logic              mem_valid,
    output mem_req_t          mem_req,
    input  logic              mem_ready,
    input  logic [data_w-1:0] mem_rdata
);

    dcache_state_t      state;
    dcache_state_t      next_state;
    cache_line_t        lines [num_lines];
    cache_line_t        cur_line;
    logic [index_w-1:0] index;
    logic [tag_w-1:0]   tag;
    logic               hit;

    assign index    = addr_index(cpu_req.addr);
    assign tag      = addr_tag(cpu_req.addr);
    assign cur_line = lines[index];
    assign hit      = cur_line.valid && (cur_line.tag == tag);

    assign cpu_ready = (state == D_COMPARE) && hit;
    assign cpu_rdata = cur_line.data;

    assign mem_valid = (state == D_WRITE_BACK) || (state == D_ALLOCATE);

    always_comb
    begin
        if (state == D_WRITE_BACK)
        begin
            // Victim address is rebuilt from the stored tag and the index
            mem_req.addr  = {cur_line.tag, index, {offset_w{1'b0}}};
            mem_req.wdata = cur_line.data;
            mem_req.wr    = 1'b1;
        end
        else
        begin
            mem_req.addr  = {cpu_req.addr[addr_w-1:offset_w], {offset_w{1'b0}}};
            mem_req.wdata = '0;
            mem_req.wr    = 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= D_IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            D_IDLE:
            begin
                if (cpu_valid)
                    next_state = D_COMPARE;
            end
            D_COMPARE:
            begin
                if (hit)
                    next_state = D_IDLE;
                else if (cur_line.valid && cur_line.dirty)
                    next_state = D_WRITE_BACK;
                else
                    next_state = D_ALLOCATE;
            end
            D_WRITE_BACK:
            begin
                if (mem_ready)
                    next_state = D_ALLOCATE;
            end
            D_ALLOCATE:
            begin
                if (mem_ready)
                    next_state = D_COMPARE;
            end
            default:
            begin
                next_state = D_IDLE;
            end
        endcase
    end

    // A write miss refills first and then completes as a write hit
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < num_lines; i++)
                lines[i] <= '0;
        end
        else if (state == D_COMPARE && hit && cpu_req.wr)
        begin
            lines[index].data  <= cpu_req.wdata;
            lines[index].dirty <= 1'b1;
        end
        else if (state == D_ALLOCATE && mem_ready)
        begin
            lines[index].valid <= 1'b1;
            lines[index].dirty <= 1'b0;
            lines[index].tag   <= tag;
            lines[index].data  <= mem_rdata;
        end
    end

endmodule

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              i_valid,
    input  mem_req_t          i_req,
    output logic              i_ready,
    input  logic              d_valid,
    input  mem_req_t          d_req,
    output logic              d_ready,
    output logic [data_w-1:0] rdata_out,
    output logic              mem_valid,
    output mem_req_t          mem_req,
    input  logic              mem_ready,
    input  logic [data_w-1:0] mem_rdata
);

    logic busy;
    logic owner_d;
    logic last_d;
    logic pick_d;
    logic sel_d;

    // On a tie the cache not served last wins
    assign pick_d = d_valid && (!i_valid || !last_d);
    assign sel_d  = busy ? owner_d : pick_d;

    assign mem_valid = sel_d ? d_valid : i_valid;
    assign mem_req   = sel_d ? d_req : i_req;
    assign i_ready   = mem_ready && !sel_d;
    assign d_ready   = mem_ready && sel_d;
    assign rdata_out = mem_rdata;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy    <= 1'b0;
            owner_d <= 1'b0;
            last_d  <= 1'b1;
        end
        else if (mem_ready)
        begin
            busy   <= 1'b0;
            last_d <= sel_d;
        end
        else if (!busy && (i_valid || d_valid))
        begin
            busy    <= 1'b1;
            owner_d <= pick_d;
        end
    end

endmodule

// File: rtl/main_memory.sv
`timescale 1ns/1ns

module main_memory
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              valid,
    input  mem_req_t          req,
    output logic              ready,
    output logic [data_w-1:0] rdata
);

    logic [data_w-1:0]    mem [mem_words];
    logic [lat_cnt_w-1:0] count;
    logic [mem_aw-1:0]    waddr;

    initial
    begin
        for (int i = 0; i < mem_words; i++)
            mem[i] = '0;
    end

    assign waddr = word_addr(req.addr);
    assign ready = valid && (count == lat_cnt_w'(mem_latency));
    assign rdata = mem[waddr];

    // Counting restarts after each ready so a held valid starts a fresh access
    always_ff @(posedge clk)
    begin
        if (rst || !valid || ready)
            count <= '0;
        else
            count <= count + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (ready && req.wr)
            mem[waddr] <= req.wdata;
    end

endmodule

// File: rtl/cache_subsystem.sv
`timescale 1ns/1ns

module cache_subsystem
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              i_valid,
    input  cpu_req_t          i_req,
    output logic              i_ready,
    output logic [data_w-1:0] i_rdata,
    input  logic              d_valid,
    input  cpu_req_t          d_req,
    output logic              d_ready,
    output logic [data_w-1:0] d_rdata
);

    logic              i_mem_valid;
    mem_req_t          i_mem_req;
    logic              i_mem_ready;
    logic              d_mem_valid;
    mem_req_t          d_mem_req;
    logic              d_mem_ready;
    logic [data_w-1:0] arb_rdata;
    logic              mem_valid;
    mem_req_t          mem_req;
    logic              mem_ready;
    logic [data_w-1:0] mem_rdata;

    icache u_icache (
        .clk       (clk),
        .rst       (rst),
        .cpu_valid (i_valid),
        .cpu_req   (i_req),
        .cpu_ready (i_ready),
        .cpu_rdata (i_rdata),
        .mem_valid (i_mem_valid),
        .mem_req   (i_mem_req),
        .mem_ready (i_mem_ready),
        .mem_rdata (arb_rdata)
    );

    dcache u_dcache (
        .clk       (clk),
        .rst       (rst),
        .cpu_valid (d_valid),
        .cpu_req   (d_req),
        .cpu_ready (d_ready),
        .cpu_rdata (d_rdata),
        .mem_valid (d_mem_valid),
        .mem_req   (d_mem_req),
        .mem_ready (d_mem_ready),
        .mem_rdata (arb_rdata)
    );

    mem_arbiter u_mem_arbiter (
        .clk       (clk),
        .rst       (rst),
        .i_valid   (i_mem_valid),
        .i_req     (i_mem_req),
        .i_ready   (i_mem_ready),
        .d_valid   (d_mem_valid),
        .d_req     (d_mem_req),
        .d_ready   (d_mem_ready),
        .rdata_out (arb_rdata),
        .mem_valid (mem_valid),
        .mem_req   (mem_req),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    main_memory u_main_memory (
        .clk   (clk),
        .rst   (rst),
        .valid (mem_valid),
        .req   (mem_req),
        .ready (mem_ready),
        .rdata (mem_rdata)
    );

endmodule

// File: dv/tb_cache_subsystem.sv
`timescale 1ns/1ns

module tb_cache_subsystem
    import cache_pkg::*;
;

    localparam int clk_period        = 20;
    localparam int num_tests         = 5;
    localparam int test_bound_cycles = 2000;
    localparam int req_bound         = 60;

    logic              clk;
    logic              rst;
    logic              i_valid;
    cpu_req_t          i_req;
    logic              i_ready;
    logic [data_w-1:0] i_rdata;
    logic              d_valid;
    cpu_req_t          d_req;
    logic              d_ready;
    logic [data_w-1:0] d_rdata;

    logic [data_w-1:0] shadow [mem_words];
    logic [31:0]       lfsr_state;
    int                errors;
    int                checks;

    cache_subsystem u_cache_subsystem (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_valid),
        .i_req   (i_req),
        .i_ready (i_ready),
        .i_rdata (i_rdata),
        .d_valid (d_valid),
        .d_req   (d_req),
        .d_ready (d_ready),
        .d_rdata (d_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < n; b++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    task automatic check_rdata(input string name, input logic [data_w-1:0] got,
                               input logic [data_w-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0t %s got=%08h exp=%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_req_done(input string name, input bit done, input int cycles,
                                  input int min_c, input int max_c);
        checks++;
        if (!done)
        begin
            errors++;
            $display("%s never pulsed within %0d cycles at %0t", name, max_c, $time);
        end
        else if (cycles < min_c || cycles > max_c)
        begin
            errors++;
            $display("[FAIL] %0t %s got=%0d cycles exp=%0d..%0d cycles",
                     $time, name, cycles, min_c, max_c);
        end
    endtask

    // Holds valid until ready, sampling the response on falling edges
    task automatic access(input bit on_d, input cpu_req_t req,
                          output logic [data_w-1:0] rdata, output int cycles, output bit done);
        @(posedge clk);
        if (on_d)
        begin
            d_valid <= 1'b1;
            d_req   <= req;
        end
        else
        begin
            i_valid <= 1'b1;
            i_req   <= req;
        end
        cycles = 0;
        @(negedge clk);
        while (!(on_d ? d_ready : i_ready) && cycles < req_bound)
        begin
            @(negedge clk);
            cycles++;
        end
        done  = on_d ? d_ready : i_ready;
        rdata = on_d ? d_rdata : i_rdata;
        @(posedge clk);
        if (on_d)
            d_valid <= 1'b0;
        else
            i_valid <= 1'b0;
    endtask

    task automatic data_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata);
        logic [data_w-1:0] rdata;
        int                cycles;
        bit                done;
        access(1'b1, '{addr: addr, wdata: wdata, wr: 1'b1}, rdata, cycles, done);
        check_req_done("d_ready", done, cycles, 1, req_bound);
        shadow[addr[addr_w-1:2]] = wdata;
    endtask

    task automatic data_read(input logic [addr_w-1:0] addr, input int min_c, input int max_c);
        logic [data_w-1:0] rdata;
        int                cycles;
        bit                done;
        access(1'b1, '{addr: addr, wdata: '0, wr: 1'b0}, rdata, cycles, done);
        check_req_done("d_ready", done, cycles, min_c, max_c);
        check_rdata("d_rdata", rdata, shadow[addr[addr_w-1:2]]);
    endtask

    task automatic fetch(input logic [addr_w-1:0] addr, input int min_c, input int max_c);
        logic [data_w-1:0] rdata;
        int                cycles;
        bit                done;
        access(1'b0, '{addr: addr, wdata: '0, wr: 1'b0}, rdata, cycles, done);
        check_req_done("i_ready", done, cycles, min_c, max_c);
        check_rdata("i_rdata", rdata, shadow[addr[addr_w-1:2]]);
    endtask

    task automatic test_data_hit();
        data_write(14'h040, 32'hcafe_0040);
        data_read(14'h040, 1, req_bound);
        // Line is resident now, so ready follows valid by exactly one cycle
        data_read(14'h040, 1, 1);
    endtask

    // 0x0c4 and 0x1c4 share index 1 with tags 3 and 7
    task automatic test_dirty_eviction();
        data_write(14'h0c4, 32'h1234_00c4);
        data_write(14'h1c4, 32'h5678_01c4);
        data_read(14'h0c4, 1, req_bound);
    endtask

    task automatic test_fetch_through_memory();
        fetch(14'h300, 1, req_bound);
        fetch(14'h0c4, 1, req_bound);
    endtask

    task automatic test_concurrent_misses();
        fork
            fetch(14'h1c4, mem_latency, req_bound);
            data_read(14'h140, mem_latency, req_bound);
        join
    endtask

    task automatic test_random_traffic();
        logic [31:0]       tag_bits;
        logic [31:0]       idx_bits;
        logic [31:0]       wr_bit;
        logic [addr_w-1:0] addr;
        for (int k = 0; k < 40; k++)
        begin
            tag_bits = take_bits(2);
            idx_bits = take_bits(4);
            wr_bit   = take_bits(1);
            addr     = {6'b0, tag_bits[1:0], idx_bits[3:0], 2'b00};
            if (wr_bit[0])
                data_write(addr, take_bits(32));
            else
                data_read(addr, 1, req_bound);
        end
    endtask

    initial
    begin
        #(num_tests * test_bound_cycles * clk_period);
        $display("Watchdog expired before the tests finished");
        $display("sim failed");
        $finish;
    end

    initial
    begin
        rst        = 1'b1;
        i_valid    = 1'b0;
        i_req      = '0;
        d_valid    = 1'b0;
        d_req      = '0;
        errors     = 0;
        checks     = 0;
        lfsr_state = 32'h2b56_555d;
        for (int i = 0; i < mem_words; i++)
            shadow[i] = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        test_data_hit();
        test_dirty_eviction();
        test_fetch_through_memory();
        test_concurrent_misses();
        test_random_traffic();

        repeat (2) @(posedge clk);
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: sim.f
rtl/cache_pkg.sv
rtl/icache.sv
rtl/dcache.sv
rtl/mem_arbiter.sv
rtl/main_memory.sv
rtl/cache_subsystem.sv
dv/tb_cache_subsystem.sv
